//--- hw/shadow_map_pkg.sv
package shadow_map_pkg;

    // word-address widths of the four shadowed memories
    localparam int vram_aw = 14;    // 32 KB video ram
    localparam int char_aw = 11;    //  4 KB character ram
    localparam int pal_aw  = 11;    //  4 KB palette ram
    localparam int obj_aw  = 10;    //  2 KB object ram

    // dump port byte address
    localparam int dump_aw = 17;    // bit 16 ignored by the map

    // region code field of the dump address
    localparam int region_msb = 15;
    localparam int region_lsb = 11;
    typedef logic [region_msb-region_lsb:0] region_code_t;

    // bank numbering, also the bit position in bank_sel_t
    typedef enum logic [1:0] {
        bank_vram = 2'd0,
        bank_char = 2'd1,
        bank_pal  = 2'd2,
        bank_obj  = 2'd3
    } bank_e;

    typedef logic [3:0] bank_sel_t;    // one-hot, index with bank_e

    localparam logic [15:0] dump_fill = 16'hffff;    // unmapped read value

    typedef logic [7:0] dump_byte_t;

    // dump address bits 15..11 to bank, all zero when unmapped
    function automatic bank_sel_t dump_region(input region_code_t code);
        bank_sel_t sel;
        sel = '0;
        casez (code)
            5'b0????: sel[bank_vram] = 1'b1;    // lower 32 KB
            5'b1000?: sel[bank_char] = 1'b1;    // 0x8000..0x8fff
            5'b1001?: sel[bank_pal]  = 1'b1;    // 0x9000..0x9fff
            5'b10100: sel[bank_obj]  = 1'b1;    // 0xa000..0xa7ff
            default:  sel = '0;                 // 0xa800 and up
        endcase
        return sel;
    endfunction

endpackage

//--- hw/shadow_bus_pkg.sv
package shadow_bus_pkg;

    import shadow_map_pkg::*;

    // one registered cpu write, shared by all banks
    // banks narrower than vram take the low address bits
    typedef struct packed {
        logic [vram_aw-1:0] addr;    // word address
        logic [15:0]        data;
        logic [1:0]         be;      // active high, bit 1 = upper byte
        bank_sel_t          sel;     // banks hit by this write
    } cpu_write_t;

    // held byte address from the host
    typedef struct packed {
        logic [dump_aw-1:0] addr;    // bit 0 picks the byte
    } dump_req_t;

    // even byte of a word is its upper half
    localparam logic even_is_upper = 1'b1;

    // word address inside the dump byte address
    function automatic logic [vram_aw-1:0] dump_word(input dump_req_t req);
        return req.addr[vram_aw:1];
    endfunction

    // byte lane selected by the dump address
    function automatic logic dump_odd(input dump_req_t req);
        return req.addr[0];
    endfunction

    // write enables as seen by a single bank
    function automatic logic [1:0] bank_be(input cpu_write_t wr, input bank_e bank);
        return wr.sel[bank] ? wr.be : 2'b00;
    endfunction

endpackage

//--- hw/shadow_ram16.sv
module shadow_ram16 #(
    parameter int aw = 10
) (
    input  logic          clk_rom,

    // write port, cpu side
    input  logic [aw-1:0] wr_addr,
    input  logic [15:0]   wr_data,
    input  logic [1:0]    wr_be,      // bit 1 = upper byte

    // read port, dump side
    input  logic [aw-1:0] rd_addr,
    output logic [15:0]   q
);

    localparam int depth = 2 ** aw;

    logic [15:0] mem [depth];    // contents survive reset

    // byte lanes written independently
    always_ff @(posedge clk_rom) begin
        if (wr_be[1]) begin
            mem[wr_addr][15:8] <= wr_data[15:8];
        end
        if (wr_be[0]) begin
            mem[wr_addr][7:0] <= wr_data[7:0];
        end
    end

    // registered read
    // same-cycle write to rd_addr shows up one read later
    always_ff @(posedge clk_rom) begin
        q <= mem[rd_addr];
    end

endmodule

//--- hw/shadow_write_capture.sv
module shadow_write_capture
    import shadow_map_pkg::*, shadow_bus_pkg::*;
(
    input  logic               clk_rom,
    input  logic               reset,

    // cpu bus, sampled every clock
    input  logic [vram_aw-1:0] addr,
    input  logic [15:0]        din,
    input  logic [1:0]         dswn,        // active low byte mask
    input  logic               char_cs,
    input  logic               vram_cs,
    input  logic               pal_cs,
    input  logic               objram_cs,

    output cpu_write_t         wr_q         // one aligned write for all banks
);

    cpu_write_t wr_d;
    logic       wr_any;

    // pack the bus into one write
    always_comb begin
        wr_d.addr            = addr;
        wr_d.data            = din;
        wr_d.be              = ~dswn;         // low mask bit enables the byte
        wr_d.sel             = '0;
        wr_d.sel[bank_vram]  = vram_cs;
        wr_d.sel[bank_char]  = char_cs;
        wr_d.sel[bank_pal]   = pal_cs;
        wr_d.sel[bank_obj]   = objram_cs;   // several selects may be high
    end

    // needs a byte and a bank, else nothing is written
    assign wr_any = (|wr_d.be) && (|wr_d.sel);

    always_ff @(posedge clk_rom) begin
        wr_q.addr <= wr_d.addr;    // payload, no reset
        wr_q.data <= wr_d.data;
        if (reset || !wr_any) begin
            wr_q.be  <= 2'b00;     // no write in the next cycle
            wr_q.sel <= '0;
        end else begin
            wr_q.be  <= wr_d.be;
            wr_q.sel <= wr_d.sel;
        end
    end

endmodule

//--- hw/shadow_dump_reader.sv
module shadow_dump_reader
    import shadow_map_pkg::*, shadow_bus_pkg::*;
(
    input  logic               clk_rom,
    input  logic               reset,

    input  dump_req_t          dump,       // held by the host for 3+ cycles

    // bank read data, one cycle after rd_addr
    input  logic [15:0]        vram_q,
    input  logic [15:0]        char_q,
    input  logic [15:0]        pal_q,
    input  logic [15:0]        obj_q,

    output logic [vram_aw-1:0] rd_addr,    // shared word address
    output dump_byte_t         ioctl_din
);

    bank_sel_t   region_d;
    bank_sel_t   region_q;      // decode aligned with ram read
    logic [15:0] word_sel;
    logic [15:0] word_latch;
    logic        odd;

    // narrower banks take the low bits
    assign rd_addr = dump_word(dump);
    assign odd     = dump_odd(dump);

    assign region_d = dump_region(dump.addr[region_msb:region_lsb]);

    // one-cycle delay to meet the registered ram output
    always_ff @(posedge clk_rom) begin
        if (reset) begin
            region_q <= '0;    // reads as unmapped
        end else begin
            region_q <= region_d;
        end
    end

    // bank word mux, at most one region bit set
    always_comb begin
        word_sel = dump_fill;    // unmapped
        if (region_q[bank_vram]) begin
            word_sel = vram_q;
        end else if (region_q[bank_char]) begin
            word_sel = char_q;
        end else if (region_q[bank_pal]) begin
            word_sel = pal_q;
        end else if (region_q[bank_obj]) begin
            word_sel = obj_q;
        end
    end

    // capture on even addresses, hold through the odd one
    always_ff @(posedge clk_rom) begin
        if (reset) begin
            word_latch <= '0;    // dump reads 0 until first capture
        end else if (!odd) begin
            word_latch <= word_sel;
        end
    end

    // byte pick follows the live address bit 0
    always_comb begin
        if (odd == even_is_upper) begin
            ioctl_din = word_latch[7:0];     // odd byte, lower half
        end else begin
            ioctl_din = word_latch[15:8];    // even byte, upper half
        end
    end

endmodule

//--- hw/shadow_capture_top.sv
module shadow_capture_top
    import shadow_map_pkg::*, shadow_bus_pkg::*;
(
    input  logic               clk_rom,
    input  logic               reset,

    // cpu writes to the video memories
    input  logic [vram_aw-1:0] addr,        // word address
    input  logic               char_cs,     //  4 KB
    input  logic               vram_cs,     // 32 KB
    input  logic               pal_cs,      //  4 KB
    input  logic               objram_cs,   //  2 KB
    input  logic [15:0]        din,
    input  logic [1:0]         dswn,        // active low

    // host dump port
    input  logic [dump_aw-1:0] ioctl_addr,  // byte address
    output dump_byte_t         ioctl_din
);

    cpu_write_t         wr_q;
    dump_req_t          dump;
    logic [vram_aw-1:0] rd_addr;
    logic [1:0]         vram_be;
    logic [1:0]         char_be;
    logic [1:0]         pal_be;
    logic [1:0]         obj_be;
    logic [15:0]        vram_q;
    logic [15:0]        char_q;
    logic [15:0]        pal_q;
    logic [15:0]        obj_q;

    assign dump.addr = ioctl_addr;

    // per-bank byte enables gated by the select
    assign vram_be = bank_be(wr_q, bank_vram);
    assign char_be = bank_be(wr_q, bank_char);
    assign pal_be  = bank_be(wr_q, bank_pal);
    assign obj_be  = bank_be(wr_q, bank_obj);

    shadow_write_capture i_capture (
        .clk_rom   (clk_rom),
        .reset     (reset),
        .addr      (addr),
        .din       (din),
        .dswn      (dswn),
        .char_cs   (char_cs),
        .vram_cs   (vram_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .wr_q      (wr_q)
    );

    shadow_ram16 #(.aw(vram_aw)) i_vram (
        .clk_rom (clk_rom),
        .wr_addr (wr_q.addr),
        .wr_data (wr_q.data),
        .wr_be   (vram_be),
        .rd_addr (rd_addr),
        .q       (vram_q)
    );

    shadow_ram16 #(.aw(char_aw)) i_char (
        .clk_rom (clk_rom),
        .wr_addr (wr_q.addr[char_aw-1:0]),
        .wr_data (wr_q.data),
        .wr_be   (char_be),
        .rd_addr (rd_addr[char_aw-1:0]),
        .q       (char_q)
    );

    shadow_ram16 #(.aw(pal_aw)) i_pal (
        .clk_rom (clk_rom),
        .wr_addr (wr_q.addr[pal_aw-1:0]),
        .wr_data (wr_q.data),
        .wr_be   (pal_be),
        .rd_addr (rd_addr[pal_aw-1:0]),
        .q       (pal_q)
    );

    shadow_ram16 #(.aw(obj_aw)) i_obj (
        .clk_rom (clk_rom),
        .wr_addr (wr_q.addr[obj_aw-1:0]),
        .wr_data (wr_q.data),
        .wr_be   (obj_be),
        .rd_addr (rd_addr[obj_aw-1:0]),
        .q       (obj_q)
    );

    shadow_dump_reader i_reader (
        .clk_rom   (clk_rom),
        .reset     (reset),
        .dump      (dump),
        .vram_q    (vram_q),
        .char_q    (char_q),
        .pal_q     (pal_q),
        .obj_q     (obj_q),
        .rd_addr   (rd_addr),
        .ioctl_din (ioctl_din)
    );

endmodule

//--- tests/shadow_assertions.sv
module shadow_assertions
    import shadow_map_pkg::*;
(
    input logic               clk_rom,
    input logic               reset,
    input logic [1:0]         vram_be,
    input logic [1:0]         char_be,
    input logic [1:0]         pal_be,
    input logic [1:0]         obj_be,
    input logic [dump_aw-1:0] ioctl_addr,
    input dump_byte_t         ioctl_din
);

    int   fail_reset   = 0;
    int   fail_unknown = 0;
    int   fail_region  = 0;
    int   failures;       // read by the testbench
    logic unmapped_even;

    assign failures = fail_reset + fail_unknown + fail_region;

    // region codes 10101 and 11xxx have no bank behind them
    assign unmapped_even = ioctl_addr[15] && (ioctl_addr[14:11] > 4'b0100) && !ioctl_addr[0];

    // wr_q cleared by reset, so no bank writes right after
    no_write_after_reset: assert property (@(posedge clk_rom)
        $fell(reset) |-> ((vram_be | char_be | pal_be | obj_be) == 2'b00))
        else begin
            $error("bank byte enable active in the first cycle after reset");
            fail_reset++;
        end

    dump_byte_known: assert property (@(posedge clk_rom) disable iff (reset)
        !$isunknown(ioctl_din))
        else begin
            $error("ioctl_din is unknown");
            fail_unknown++;
        end

    // decode, then latch, so the fill shows two edges later
    unmapped_reads_fill: assert property (@(posedge clk_rom) disable iff (reset)
        (unmapped_even && $past(unmapped_even)) |=> (ioctl_din == 8'hff))
        else begin
            $error("unmapped dump address did not read back the fill value");
            fail_region++;
        end

endmodule

bind shadow_capture_top shadow_assertions i_assert (
    .clk_rom    (clk_rom),
    .reset      (reset),
    .vram_be    (vram_be),
    .char_be    (char_be),
    .pal_be     (pal_be),
    .obj_be     (obj_be),
    .ioctl_addr (ioctl_addr),
    .ioctl_din  (ioctl_din)
);

//--- tests/shadow_tb.sv
module shadow_tb
    import shadow_map_pkg::*;
();

    localparam int    clk_period = 8;
    localparam string trace_path = "tests/shadow_trace.txt";
    localparam logic [dump_aw-1:0] idle_addr = 17'h0a801;    // odd and unmapped, latch holds

    logic               clk_rom;
    logic               reset;
    logic [vram_aw-1:0] addr;
    logic               char_cs;
    logic               vram_cs;
    logic               pal_cs;
    logic               objram_cs;
    logic [15:0]        din;
    logic [1:0]         dswn;
    logic [dump_aw-1:0] ioctl_addr;
    dump_byte_t         ioctl_din;

    int    cycle_count  = 0;
    int    cycle_limit  = 0;     // set once the trace is counted
    int    error_count  = 0;
    int    check_count  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    test_checks  = 0;     // per test
    int    test_errors  = 0;
    bit    test_open    = 1'b0;
    string test_name;

    shadow_capture_top i_dut (
        .clk_rom    (clk_rom),
        .reset      (reset),
        .addr       (addr),
        .char_cs    (char_cs),
        .vram_cs    (vram_cs),
        .pal_cs     (pal_cs),
        .objram_cs  (objram_cs),
        .din        (din),
        .dswn       (dswn),
        .ioctl_addr (ioctl_addr),
        .ioctl_din  (ioctl_din)
    );

    initial begin
        clk_rom = 1'b0;
        forever #(clk_period / 2) clk_rom = ~clk_rom;
    end

    // run limit scales with trace length
    always @(posedge clk_rom) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run was still going after %0d clock cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_byte(input logic [dump_aw-1:0] at, input dump_byte_t got,
                              input dump_byte_t exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            $display("MISMATCH ioctl_din at %05h: got %02h, expected %02h", at, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    // one cpu write, then a spare cycle so the ram has it before a dump read
    task automatic drive_write(input string banks, input logic [vram_aw-1:0] a,
                               input logic [15:0] d, input logic [1:0] m);
        byte c;
        int  i;
        for (i = 0; i < banks.len(); i++) begin
            c = banks.getc(i);
            case (c)
                "v": vram_cs   = 1'b1;
                "c": char_cs   = 1'b1;
                "p": pal_cs    = 1'b1;
                "o": objram_cs = 1'b1;
                default: begin
                    $display("trace names an unknown bank letter %c", c);
                    error_count++;
                    test_errors++;
                end
            endcase
        end
        addr = a;
        din  = d;
        dswn = m;    // active low
        @(negedge clk_rom);
        vram_cs   = 1'b0;
        char_cs   = 1'b0;
        pal_cs    = 1'b0;
        objram_cs = 1'b0;
        dswn      = 2'b11;
        @(negedge clk_rom);    // wr_q lands in the ram here
    endtask

    task automatic dump_held(input logic [dump_aw-1:0] a, input dump_byte_t exp);
        ioctl_addr = a;
        repeat (3) @(negedge clk_rom);    // host hold time
        check_byte(a, ioctl_din, exp);    // just before the address moves
    endtask

    // short dump, sampled ahead of the first latch capture
    task automatic dump_early(input logic [dump_aw-1:0] a, input dump_byte_t exp);
        ioctl_addr = a;
        #(clk_period / 4);
        check_byte(a, ioctl_din, exp);
        @(negedge clk_rom);
        ioctl_addr = idle_addr;
        @(negedge clk_rom);    // idle decode gets one edge
    endtask

    task automatic close_test();
        if (test_open) begin
            if (test_errors == 0) begin
                tests_passed++;
                $display("test %s: pass, %0d checks", test_name, test_checks);
            end else begin
                tests_failed++;
                $display("test %s: FAIL, %0d errors in %0d checks", test_name, test_errors,
                         test_checks);
            end
        end
        test_open   = 1'b0;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_line(input string line, input int line_no);
        string              banks;
        logic [vram_aw-1:0] w_addr;
        logic [15:0]        w_data;
        logic [1:0]         w_mask;
        logic [dump_aw-1:0] d_addr;
        dump_byte_t         d_exp;
        bit                 ok;
        ok = 1'b0;
        case (line.getc(0))
            "#", "\n": ok = 1'b1;    // comment or blank
            "T": begin
                close_test();
                ok        = ($sscanf(line, "T %s", test_name) == 1);
                test_open = ok;
            end
            "W": if ($sscanf(line, "W %s %h %h %h", banks, w_addr, w_data, w_mask) == 4) begin
                drive_write(banks, w_addr, w_data, w_mask);
                ok = 1'b1;
            end
            "D": if ($sscanf(line, "D %h %h", d_addr, d_exp) == 2) begin
                dump_held(d_addr, d_exp);
                ok = 1'b1;
            end
            "P": if ($sscanf(line, "P %h %h", d_addr, d_exp) == 2) begin
                dump_early(d_addr, d_exp);
                ok = 1'b1;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            $display("trace line %0d could not be read: %s", line_no, line);
            error_count++;
        end
    endtask

    initial begin
        string line;
        int    fd;
        int    line_total;
        int    line_no;
        reset      = 1'b1;
        addr       = '0;
        char_cs    = 1'b1;     // write held through reset, must not reach a bank
        vram_cs    = 1'b1;
        pal_cs     = 1'b1;
        objram_cs  = 1'b1;
        din        = 16'h5a5a;
        dswn       = 2'b00;    // both bytes enabled
        ioctl_addr = idle_addr;
        line_total = 0;
        line_no    = 0;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", trace_path);
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_total++;
            end
            $fclose(fd);
            fd = $fopen(trace_path, "r");    // second pass runs it
        end
        cycle_limit = 4 * line_total + 50;
        repeat (3) @(posedge clk_rom);
        @(negedge clk_rom);
        reset     = 1'b0;
        char_cs   = 1'b0;
        vram_cs   = 1'b0;
        pal_cs    = 1'b0;
        objram_cs = 1'b0;
        dswn      = 2'b11;    // bus idle from here
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                run_line(line, line_no);
            end
            $fclose(fd);
        end
        close_test();
        error_count += i_dut.i_assert.failures;    // bound checker count
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d", tests_passed,
                 tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/shadow_trace.txt
# W banks word_addr data dswn : cpu write, banks from v c p o, dswn active low
# D byte_addr expected : dump held 3 cycles, P samples before the first capture
T reset_state
P 00001 00
P 00000 00
T full_words
W v 0012 1234 0
W c 0012 5678 0
W p 0012 9abc 0
W o 0012 def0 0
D 00024 12
D 00025 34
D 08024 56
D 08025 78
D 09024 9a
D 09025 bc
D 0a024 de
D 0a025 f0
T byte_masks
W v 0040 aabb 0
W v 0040 11cc 1
W c 0007 ccdd 0
W c 0007 ee99 2
D 00080 11
D 00081 bb
D 0800e cc
D 0800f 99
T bank_isolation
W vcpo 0055 0000 0
W c 0055 4321 0
W vp 0055 a5a5 0
D 000aa a5
D 000ab a5
D 080aa 43
D 080ab 21
D 090aa a5
D 090ab a5
D 0a0aa 00
D 0a0ab 00
T unmapped
D 0a800 ff
D 0a801 ff
D 0c024 ff
D 0c025 ff
D 0f000 ff
D 0ffff ff
T wrap_bit16
W o 03ff 7e81 0
W v 0024 c3d4 0
D 0a7fe 7e
D 0a7ff 81
D 1a7fe 7e
D 1a7ff 81
D 10048 c3
D 10049 d4
D 00048 c3
D 00049 d4

//--- all.f
hw/shadow_map_pkg.sv
hw/shadow_bus_pkg.sv
hw/shadow_ram16.sv
hw/shadow_write_capture.sv
hw/shadow_dump_reader.sv
hw/shadow_capture_top.sv
tests/shadow_assertions.sv
tests/shadow_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := shadow_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM_LOG   := sim.log
SIM_ARGS  := +verilator+error+limit+100
PASS_TEXT := Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	grep -q "$(PASS_TEXT)" $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
